// File: logic/sdram_access_counter.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_access_counter #(
  parameter int T_RCD       = 2,
  parameter int CAS_LATENCY = 2
) (
  input  wire                           clock,
  input  wire                           reset,
  input  wire [sdram_pkg::BANK_W-1:0]   start_bank,
  input  wire [sdram_pkg::ROW_W-1:0]    start_row,
  input  wire [sdram_pkg::COL_W-1:0]    start_col,
  input  wire [2:0]                     access_count,  // N - 1
  sdram_seq_if.counter                  seq
);

  // Timer holds at the longer wait
  localparam int WAIT_MAX = (T_RCD > CAS_LATENCY) ? T_RCD : CAS_LATENCY;

  logic [sdram_pkg::ADDR_W-1:0] addr_q;    // {bank, row, column}
  logic [2:0]                   index_q;   // Access number
  logic [2:0]                   count_q;   // Latched access_count
  logic                         loaded_q;  // Operation in flight

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      index_q  <= '0;
      count_q  <= '0;
      loaded_q <= 1'b0;
    end else if (seq.load_start) begin
      index_q  <= '0;
      count_q  <= access_count;
      loaded_q <= 1'b1;
    end else if (seq.advance) begin
      index_q <= index_q + 3'd1;
      if (seq.last_access) loaded_q <= 1'b0;  // Operation complete
    end
  end

  // Column carries into row, row into bank
  always_ff @(posedge clock) begin
    if (seq.load_start) addr_q <= {start_bank, start_row, start_col};
    else if (seq.advance) addr_q <= addr_q + 1'b1;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) seq.wait_count <= '0;
    else if (seq.wait_clear) seq.wait_count <= '0;
    else if (int'(seq.wait_count) < WAIT_MAX) seq.wait_count <= seq.wait_count + 1'b1;
  end

  assign {seq.cur_bank, seq.cur_row, seq.cur_col} = addr_q;
  assign seq.first_access = (index_q == 3'd0);
  assign seq.last_access  = (index_q == count_q);

  // At most five accesses per operation
  a_count_range: assert property (@(posedge clock) disable iff (reset)
    seq.load_start |-> access_count <= 3'd4);

  // Stepping needs a loaded start address
  a_advance_loaded: assert property (@(posedge clock) disable iff (reset)
    seq.advance |-> loaded_q);

endmodule

`default_nettype wire

// File: logic/sdram_access_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_access_fsm #(
  parameter int T_RCD       = 2,
  parameter int CAS_LATENCY = 2
) (
  input  wire                             clock,
  input  wire                             reset,
  input  wire                             start,        // One-cycle request strobe
  input  sdram_pkg::op_kind_t             op,
  input  wire [1:0]                       first_lanes,  // {upper, lower} of access 0
  sdram_seq_if.fsm                        seq,
  output logic [1:0]                      lanes,        // Mask of current access
  output logic                            drive_dq,
  output logic                            shift_out,
  output logic                            capture_in,
  output logic                            clear_word,
  output logic                            done,
  output sdram_pkg::sdram_cmd_t           dram_cmd,
  output logic [sdram_pkg::ROW_W-1:0]     dram_addr,
  output logic [sdram_pkg::BANK_W-1:0]    dram_ba,
  output logic [1:0]                      dram_dqm      // {udqm, ldqm}, 1 masks
);

  sdram_pkg::access_state_t state_q;
  sdram_pkg::access_state_t state_d;
  sdram_pkg::op_kind_t      op_q;       // Direction of this operation
  logic [1:0]               first_q;    // Normalized first lane mask
  logic [1:0]               lanes_q;    // 00 only in idle and load
  logic [1:0]               prep_lanes; // Mask chosen for the next access

  // Lane rule, first wins over last when N is 1
  always_comb begin
    if (seq.first_access) prep_lanes = first_q;
    else if (seq.last_access) prep_lanes = {first_q[0], first_q[1]};  // Swapped lanes
    else prep_lanes = 2'b11;                                           // Middle access
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= sdram_pkg::st_idle;
      op_q    <= sdram_pkg::op_read;
      first_q <= 2'b11;
      lanes_q <= 2'b00;
    end else begin
      state_q <= state_d;
      case (state_q)
        sdram_pkg::st_load: begin
          op_q    <= op;
          first_q <= (first_lanes == 2'b00) ? 2'b11 : first_lanes;  // 00 means both
          lanes_q <= 2'b11;  // Marks busy until prep
        end
        sdram_pkg::st_prep: lanes_q <= prep_lanes;
        sdram_pkg::st_finish: begin
          if (seq.last_access) lanes_q <= 2'b00;  // Back to idle marker
        end
        default: lanes_q <= lanes_q;
      endcase
    end
  end

  always_comb begin
    state_d        = state_q;
    seq.load_start = 1'b0;
    seq.wait_clear = 1'b0;
    seq.advance    = 1'b0;
    done           = 1'b0;
    dram_cmd       = sdram_pkg::cmd_nop;
    dram_addr      = '0;
    dram_ba        = '0;
    dram_dqm       = 2'b11;  // Bus masked by default
    case (state_q)
      sdram_pkg::st_idle: begin
        if (start) state_d = sdram_pkg::st_load;  // Strobe only seen here
      end
      sdram_pkg::st_load: begin
        seq.load_start = 1'b1;
        state_d        = sdram_pkg::st_prep;
      end
      sdram_pkg::st_prep: state_d = sdram_pkg::st_activate;
      sdram_pkg::st_activate: begin
        dram_cmd       = sdram_pkg::cmd_active;
        dram_addr      = seq.cur_row;
        dram_ba        = seq.cur_bank;
        seq.wait_clear = 1'b1;  // Timer counts tRCD from here
        state_d        = sdram_pkg::st_rcd_wait;
      end
      sdram_pkg::st_rcd_wait: begin
        if (int'(seq.wait_count) == T_RCD - 1) state_d = sdram_pkg::st_access;
      end
      sdram_pkg::st_access: begin
        dram_cmd       = (op_q == sdram_pkg::op_write) ? sdram_pkg::cmd_write
                                                       : sdram_pkg::cmd_read;
        // A10 high selects auto-precharge
        dram_addr      = {{(sdram_pkg::ROW_W - sdram_pkg::COL_W - 1){1'b0}}, 1'b1, seq.cur_col};
        dram_ba        = seq.cur_bank;
        dram_dqm       = ~lanes_q;  // Enabled lanes unmasked
        seq.wait_clear = 1'b1;
        state_d        = (CAS_LATENCY > 1) ? sdram_pkg::st_cas_wait : sdram_pkg::st_finish;
      end
      sdram_pkg::st_cas_wait: begin
        if (int'(seq.wait_count) == CAS_LATENCY - 2) state_d = sdram_pkg::st_finish;
      end
      sdram_pkg::st_finish: begin
        seq.advance = 1'b1;  // Next column, next index
        if (seq.last_access) begin
          done    = 1'b1;
          state_d = sdram_pkg::st_idle;
        end else begin
          state_d = sdram_pkg::st_prep;
        end
      end
      default: state_d = sdram_pkg::st_idle;
    endcase
  end

  assign lanes      = lanes_q;
  assign drive_dq   = (state_q == sdram_pkg::st_access) && (op_q == sdram_pkg::op_write);
  assign shift_out  = (state_q == sdram_pkg::st_access) && (op_q == sdram_pkg::op_write);
  assign capture_in = (state_q == sdram_pkg::st_finish) && (op_q == sdram_pkg::op_read);
  assign clear_word = (state_q == sdram_pkg::st_load);

  // Mask picked in prep must enable at least one lane
  a_lanes_enabled: assert property (@(posedge clock) disable iff (reset)
    state_q == sdram_pkg::st_access |-> lanes_q != 2'b00);

  // Completion only from the last finish, then straight to idle
  a_done_in_finish: assert property (@(posedge clock) disable iff (reset)
    done |-> state_q == sdram_pkg::st_finish ##1 state_q == sdram_pkg::st_idle && !done);

endmodule

`default_nettype wire

// File: logic/sdram_lane_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_lane_shifter (
  input  wire                           clock,
  input  wire                           reset,
  input  wire [sdram_pkg::WORD_W-1:0]   write_data,
  input  wire                           start,
  input  wire [1:0]                     lanes,       // {upper, lower}, 1 enabled
  input  wire                           drive_dq,
  input  wire                           shift_out,
  input  wire                           capture_in,
  input  wire                           clear_word,
  output logic [sdram_pkg::WORD_W-1:0]  read_data,
  inout  wire [sdram_pkg::DQ_W-1:0]     dram_dq
);

  localparam int W = sdram_pkg::WORD_W;

  logic [W-1:0] wr_shift_q;  // Next byte sits at the top
  logic [W-1:0] rd_shift_q;  // Newest byte at the bottom
  logic         idle;
  logic [7:0]   lower_byte;

  // Lane mask is 00 only in idle and load
  assign idle = (lanes == 2'b00) && !clear_word;

  always_ff @(posedge clock) begin
    if (start && idle) begin
      wr_shift_q <= write_data;
    end else if (shift_out) begin
      if (lanes == 2'b11) wr_shift_q <= {wr_shift_q[W-17:0], 16'h0000};  // Two bytes gone
      else wr_shift_q <= {wr_shift_q[W-9:0], 8'h00};                     // One byte gone
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rd_shift_q <= '0;
    end else if (clear_word) begin
      rd_shift_q <= '0;  // Fresh word per operation
    end else if (capture_in) begin
      case (lanes)
        2'b11: rd_shift_q <= {rd_shift_q[W-17:0], dram_dq};        // Upper then lower
        2'b10: rd_shift_q <= {rd_shift_q[W-9:0], dram_dq[15:8]};   // Upper only
        2'b01: rd_shift_q <= {rd_shift_q[W-9:0], dram_dq[7:0]};    // Lower only
        default: rd_shift_q <= rd_shift_q;
      endcase
    end
  end

  assign read_data = rd_shift_q;

  // Upper lane takes the earlier byte when both are on
  assign lower_byte = lanes[1] ? wr_shift_q[W-9 -: 8] : wr_shift_q[W-1 -: 8];

  assign dram_dq[15:8] = (drive_dq && lanes[1]) ? wr_shift_q[W-1 -: 8] : 8'hzz;
  assign dram_dq[7:0]  = (drive_dq && lanes[0]) ? lower_byte : 8'hzz;

  // Bus never driven in the read sampling cycle
  a_no_contention: assert property (@(posedge clock) disable iff (reset)
    !(drive_dq && capture_in));

endmodule

`default_nettype wire

// File: logic/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

  // Address geometry of the 16-bit SDR part
  localparam int ROW_W  = 13;                      // Row address bits
  localparam int COL_W  = 10;                      // Column address bits
  localparam int BANK_W = 2;                       // Bank select bits
  localparam int ADDR_W = BANK_W + ROW_W + COL_W;  // Linear {bank, row, column}, 25 bits

  // Data widths
  localparam int WORD_W = 64;  // Host word
  localparam int DQ_W   = 16;  // SDRAM data bus, two byte lanes

  // Controller FSM states, one access is prep through finish
  typedef enum logic [2:0] {
    st_idle     = 3'd0,  // Waiting for start
    st_load     = 3'd1,  // Latch address, op and lanes
    st_prep     = 3'd2,  // Pick lane mask of this access
    st_activate = 3'd3,  // ACTIVE to open the row
    st_rcd_wait = 3'd4,  // tRCD gap
    st_access   = 3'd5,  // READ or WRITE with auto-precharge
    st_cas_wait = 3'd6,  // CAS latency gap
    st_finish   = 3'd7   // Read data lands, step address
  } access_state_t;

  // Command pins as {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    cmd_active = 4'b0011,  // Row open
    cmd_write  = 4'b0100,  // Column write
    cmd_read   = 4'b0101,  // Column read
    cmd_nop    = 4'b0111   // Chip selected, no operation
  } sdram_cmd_t;

  // Requested transfer direction
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } op_kind_t;

endpackage

`default_nettype wire

// File: logic/sdram_rw_top.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_rw_top #(
  parameter int T_RCD       = 2,  // ACTIVE to READ/WRITE cycles
  parameter int CAS_LATENCY = 2   // READ to data cycles
) (
  input  wire                            clock,
  input  wire                            reset,
  input  wire                            start,
  input  sdram_pkg::op_kind_t            op,
  input  wire [sdram_pkg::BANK_W-1:0]    start_bank,
  input  wire [sdram_pkg::ROW_W-1:0]     start_row,
  input  wire [sdram_pkg::COL_W-1:0]     start_col,
  input  wire [1:0]                      first_lanes,
  input  wire [2:0]                      access_count,
  input  wire [sdram_pkg::WORD_W-1:0]    write_data,
  output wire [sdram_pkg::WORD_W-1:0]    read_data,
  output wire                            done,
  output wire                            dram_cs_n,
  output wire                            dram_ras_n,
  output wire                            dram_cas_n,
  output wire                            dram_we_n,
  output wire [sdram_pkg::ROW_W-1:0]     dram_addr,
  output wire [sdram_pkg::BANK_W-1:0]    dram_ba,
  output wire                            dram_ldqm,
  output wire                            dram_udqm,
  inout  wire [sdram_pkg::DQ_W-1:0]      dram_dq
);

  sdram_pkg::sdram_cmd_t dram_cmd;
  wire [1:0]             dram_dqm;     // {udqm, ldqm}
  wire [1:0]             lanes;
  wire                   drive_dq;
  wire                   shift_out;
  wire                   capture_in;
  wire                   clear_word;

  sdram_seq_if #(.T_RCD(T_RCD), .CAS_LATENCY(CAS_LATENCY)) i_seq_if ();

  sdram_access_fsm #(.T_RCD(T_RCD), .CAS_LATENCY(CAS_LATENCY)) i_access_fsm (
    .clock       (clock),
    .reset       (reset),
    .start       (start),
    .op          (op),
    .first_lanes (first_lanes),
    .seq         (i_seq_if.fsm),
    .lanes       (lanes),
    .drive_dq    (drive_dq),
    .shift_out   (shift_out),
    .capture_in  (capture_in),
    .clear_word  (clear_word),
    .done        (done),
    .dram_cmd    (dram_cmd),
    .dram_addr   (dram_addr),
    .dram_ba     (dram_ba),
    .dram_dqm    (dram_dqm)
  );

  sdram_access_counter #(.T_RCD(T_RCD), .CAS_LATENCY(CAS_LATENCY)) i_access_counter (
    .clock        (clock),
    .reset        (reset),
    .start_bank   (start_bank),
    .start_row    (start_row),
    .start_col    (start_col),
    .access_count (access_count),
    .seq          (i_seq_if.counter)
  );

  sdram_lane_shifter i_lane_shifter (
    .clock      (clock),
    .reset      (reset),
    .write_data (write_data),
    .start      (start),
    .lanes      (lanes),
    .drive_dq   (drive_dq),
    .shift_out  (shift_out),
    .capture_in (capture_in),
    .clear_word (clear_word),
    .read_data  (read_data),
    .dram_dq    (dram_dq)
  );

  // Command and mask pins
  assign {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} = dram_cmd;
  assign {dram_udqm, dram_ldqm} = dram_dqm;

endmodule

`default_nettype wire

// File: logic/sdram_seq_if.sv
`timescale 1ns/1ns
`default_nettype none

interface sdram_seq_if #(
  parameter int T_RCD       = 2,
  parameter int CAS_LATENCY = 2
);

  // Timer must reach the longer of the two waits
  localparam int WAIT_MAX = (T_RCD > CAS_LATENCY) ? T_RCD : CAS_LATENCY;
  localparam int WAIT_W   = $clog2(WAIT_MAX + 1);

  logic                          load_start;    // Load start address, clear index
  logic                          wait_clear;    // Restart timer
  logic                          advance;       // Next column and next access
  logic [WAIT_W-1:0]             wait_count;    // Cycles since last clear
  logic                          first_access;  // Index is zero
  logic                          last_access;   // Index equals access count
  logic [sdram_pkg::BANK_W-1:0]  cur_bank;      // Current bank
  logic [sdram_pkg::ROW_W-1:0]   cur_row;       // Current row
  logic [sdram_pkg::COL_W-1:0]   cur_col;       // Current column

  modport fsm (
    output load_start, wait_clear, advance,
    input  wait_count, first_access, last_access,
    input  cur_bank, cur_row, cur_col
  );

  modport counter (
    input  load_start, wait_clear, advance,
    output wait_count, first_access, last_access,
    output cur_bank, cur_row, cur_col
  );

endinterface

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sdram_rw -f tb.f -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

echo "Simulation completed"
exit 0

// File: tb.f
logic/sdram_pkg.sv
logic/sdram_seq_if.sv
logic/sdram_access_fsm.sv
logic/sdram_access_counter.sv
logic/sdram_lane_shifter.sv
logic/sdram_rw_top.sv
testbench/sdram_model.sv
testbench/tb_sdram_rw.sv

// File: testbench/sdram_model.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_model #(
  parameter int T_RCD       = 2,
  parameter int CAS_LATENCY = 2
) (
  input  wire        clock,
  input  wire        cs_n,
  input  wire        ras_n,
  input  wire        cas_n,
  input  wire        we_n,
  input  wire [12:0] addr,
  input  wire [1:0]  ba,
  input  wire        ldqm,
  input  wire        udqm,
  inout  wire [15:0] dq,
  output wire        rcd_violation  // Sticky flag for a bad column command
);

  logic [15:0]            mem [logic [24:0]];      // Written words by {bank, row, column}
  logic [12:0]            open_row [4];            // Row opened by ACTIVE
  int                     act_cycle [4];           // Cycle of last ACTIVE per bank
  logic [3:0]             row_open = 4'b0000;
  int                     cycle = 0;
  logic                   violation_q = 1'b0;
  logic [CAS_LATENCY-1:0] rd_valid = '0;           // Read return pipeline
  logic [15:0]            rd_word [CAS_LATENCY];
  logic [3:0]             cmd;
  logic [24:0]            waddr;

  assign cmd           = {cs_n, ras_n, cas_n, we_n};
  assign waddr         = {ba, open_row[ba], addr[9:0]};  // A10 is auto-precharge
  assign rcd_violation = violation_q;

  // Data bus driven only in the read return cycle
  assign dq = rd_valid[CAS_LATENCY-1] ? rd_word[CAS_LATENCY-1] : 16'hzzzz;

  // Unwritten words read back an address-dependent pattern
  function automatic logic [15:0] stored_word(input logic [24:0] a);
    if (mem.exists(a)) return mem[a];
    return a[15:0] ^ {a[24:16], a[24:18]};
  endfunction

  always @(posedge clock) begin
    logic [15:0] word;
    cycle <= cycle + 1;
    for (int i = CAS_LATENCY - 1; i > 0; i--) begin
      rd_valid[i] <= rd_valid[i-1];
      rd_word[i]  <= rd_word[i-1];
    end
    rd_valid[0] <= 1'b0;
    case (cmd)
      4'b0011: begin                     // ACTIVE
        open_row[ba]  <= addr;
        act_cycle[ba] <= cycle;
        row_open[ba]  <= 1'b1;
      end
      4'b0101, 4'b0100: begin            // READ, WRITE
        // Row open for tRCD and A10 high for auto-precharge
        if (!row_open[ba] || !addr[10] || cycle - act_cycle[ba] < T_RCD) violation_q <= 1'b1;
        word = stored_word(waddr);
        if (we_n) begin
          rd_valid[0] <= 1'b1;           // Data out CAS_LATENCY cycles later
          rd_word[0]  <= word;
        end else begin
          if (!udqm) word[15:8] = dq[15:8];  // Byte masks
          if (!ldqm) word[7:0] = dq[7:0];
          mem[waddr] = word;
        end
        row_open[ba] <= 1'b0;            // Auto-precharge closes the row
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: testbench/tb_sdram_rw.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_rw;

  localparam int T_RCD       = 2;
  localparam int CAS_LATENCY = 2;
  localparam int ACCESS_CYC  = T_RCD + CAS_LATENCY + 3;  // Cycles per access

  logic                clock;
  logic                reset;
  logic                start;
  sdram_pkg::op_kind_t op;
  logic [1:0]          start_bank;
  logic [12:0]         start_row;
  logic [9:0]          start_col;
  logic [1:0]          first_lanes;
  logic [2:0]          access_count;
  logic [63:0]         write_data;
  wire  [63:0]         read_data;
  wire                 done;
  wire                 dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n;
  wire  [12:0]         dram_addr;
  wire  [1:0]          dram_ba;
  wire                 dram_ldqm, dram_udqm;
  wire  [15:0]         dram_dq;
  wire                 rcd_violation;
  logic                busy;                  // Operation in flight

  logic [7:0]          ref_mem [logic [25:0]];  // Keyed by {word address, lane} with lane 0 upper
  logic [25:0]         byte_list [$];          // Byte order of the current operation

  sdram_rw_top #(.T_RCD(T_RCD), .CAS_LATENCY(CAS_LATENCY)) i_sdram_rw_top (
    .clock(clock), .reset(reset), .start(start), .op(op),
    .start_bank(start_bank), .start_row(start_row), .start_col(start_col),
    .first_lanes(first_lanes), .access_count(access_count),
    .write_data(write_data), .read_data(read_data), .done(done),
    .dram_cs_n(dram_cs_n), .dram_ras_n(dram_ras_n), .dram_cas_n(dram_cas_n),
    .dram_we_n(dram_we_n), .dram_addr(dram_addr), .dram_ba(dram_ba),
    .dram_ldqm(dram_ldqm), .dram_udqm(dram_udqm), .dram_dq(dram_dq)
  );

  sdram_model #(.T_RCD(T_RCD), .CAS_LATENCY(CAS_LATENCY)) i_sdram_model (
    .clock(clock), .cs_n(dram_cs_n), .ras_n(dram_ras_n), .cas_n(dram_cas_n),
    .we_n(dram_we_n), .addr(dram_addr), .ba(dram_ba), .ldqm(dram_ldqm),
    .udqm(dram_udqm), .dq(dram_dq), .rcd_violation(rcd_violation)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    assert (actual === expected)
      else stop_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
  endtask

  // NOP with both byte lanes masked whenever no operation runs
  a_idle_pins: assert property (@(posedge clock) disable iff (reset)
    !busy |-> ({dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} == 4'b0111
               && {dram_udqm, dram_ldqm} == 2'b11 && !done))
    else stop_run("command or mask pins active, or done high, between operations");

  a_rcd_gap: assert property (@(posedge clock) !rcd_violation)
    else stop_run("READ or WRITE too soon after ACTIVE, to a closed row or without auto-precharge");

  // Byte addresses in transfer order from the lane rule
  task automatic build_byte_list(input logic [24:0] addr, input logic [1:0] fl, input int n);
    logic [1:0]  first;
    logic [1:0]  mask;
    logic [24:0] word;
    first = (fl == 2'b00) ? 2'b11 : fl;
    byte_list.delete();
    for (int i = 0; i < n; i++) begin
      if (i == 0) mask = first;
      else if (i == n - 1) mask = {first[0], first[1]};  // Opposite lane
      else mask = 2'b11;
      word = addr + 25'(i);                               // Carries into row and bank
      if (mask[1]) byte_list.push_back({word, 1'b0});
      if (mask[0]) byte_list.push_back({word, 1'b1});
    end
  endtask

  task automatic run_op(input string name, input sdram_pkg::op_kind_t kind,
                        input logic [24:0] addr, input logic [1:0] fl, input int n,
                        input logic [63:0] wdata, input bit stray);
    int          cycles;
    int          expect_cyc;
    bit          seen;
    logic [63:0] shifted;
    logic [63:0] expect_word;
    build_byte_list(addr, fl, n);
    expect_cyc = 1 + n * ACCESS_CYC;
    @(posedge clock);
    start        <= 1'b1;
    op           <= kind;
    {start_bank, start_row, start_col} <= addr;
    first_lanes  <= fl;
    access_count <= 3'(n - 1);
    write_data   <= wdata;
    busy         <= 1'b1;
    cycles = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(posedge clock);
      if (stray && cycles == 4) begin
        start      <= 1'b1;      // Ignored while busy
        write_data <= ~wdata;
      end else begin
        start <= 1'b0;
      end
      @(negedge clock);
      cycles++;
      seen = done;
      if (!seen && cycles > expect_cyc + 16)
        stop_run($sformatf("timeout waiting for done in %s", name));
    end
    assert (cycles == expect_cyc)
      else stop_run($sformatf("mismatch %s expected %0d actual %0d", name, expect_cyc, cycles));
    @(posedge clock);
    busy <= 1'b0;
    @(negedge clock);            // read_data settled
    if (kind == sdram_pkg::op_write) begin
      shifted = wdata;
      foreach (byte_list[k]) begin
        ref_mem[byte_list[k]] = shifted[63:56];  // Most significant byte first
        shifted = shifted << 8;
      end
    end else begin
      expect_word = '0;
      foreach (byte_list[k]) expect_word = {expect_word[55:0], ref_mem[byte_list[k]]};
      check_word(name, expect_word, read_data);
    end
  endtask

  initial begin
    logic [24:0] a;
    logic [1:0]  fl;
    logic [63:0] w_full;
    logic [63:0] w_pre;
    logic [63:0] w_odd;
    logic [63:0] w_short;
    int          n;
    void'($urandom(32'h0b91_2742));
    reset        = 1'b1;
    start        = 1'b0;
    op           = sdram_pkg::op_read;
    start_bank   = '0;
    start_row    = '0;
    start_col    = '0;
    first_lanes  = 2'b11;
    access_count = '0;
    write_data   = '0;
    busy         = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    // Full word with stray strobes while busy
    a      = 25'($urandom);
    w_full = {$urandom, $urandom};
    run_op("full_write", sdram_pkg::op_write, a, 2'b11, 4, w_full, 1'b1);
    run_op("full_read", sdram_pkg::op_read, a, 2'b11, 4, '0, 1'b1);
    repeat (3) @(negedge clock);  // read_data holds after done
    check_word("full_read_word", w_full, read_data);

    // Odd start of 8 + 48 + 8 bits over a prefilled word
    a     = 25'($urandom);
    w_pre = {$urandom, $urandom};
    w_odd = {$urandom, $urandom};
    run_op("odd_prefill", sdram_pkg::op_write, a, 2'b11, 4, w_pre, 1'b0);
    run_op("odd_write", sdram_pkg::op_write, a, 2'b01, 5, w_odd, 1'b0);
    run_op("odd_read", sdram_pkg::op_read, a, 2'b01, 5, '0, 1'b0);
    check_word("odd_read_word", w_odd, read_data);
    run_op("odd_full_read", sdram_pkg::op_read, a, 2'b11, 4, '0, 1'b0);
    check_word("odd_full_word", {w_pre[63:56], w_odd[63:8]}, read_data);

    // Short transfers of at most eight bytes
    repeat (12) begin
      do begin
        n  = 1 + int'($urandom % 5);
        fl = 2'($urandom);
      end while (n == 5 && (fl == 2'b00 || fl == 2'b11));
      a       = 25'($urandom);
      w_short = {$urandom, $urandom};
      run_op("short_write", sdram_pkg::op_write, a, fl, n, w_short, 1'b0);
      run_op("short_read", sdram_pkg::op_read, a, fl, n, '0, 1'b0);
      check_word("short_read_word", w_short >> (64 - 8 * byte_list.size()), read_data);
    end

    // Last column of the last row carries into the next bank
    a      = {2'($urandom % 3), 13'h1fff, 10'h3ff};
    w_full = {$urandom, $urandom};
    run_op("carry_write", sdram_pkg::op_write, a, 2'b11, 4, w_full, 1'b1);
    run_op("carry_next_bank", sdram_pkg::op_read, {a[24:23] + 2'd1, 13'h0000, 10'h000},
           2'b11, 3, '0, 1'b0);
    check_word("carry_next_word", {16'h0000, w_full[47:0]}, read_data);
    run_op("carry_read", sdram_pkg::op_read, a, 2'b11, 4, '0, 1'b0);
    check_word("carry_read_word", w_full, read_data);

    repeat (4) @(posedge clock);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
